/* logic/pma_pkg.sv */
package pma_pkg;

  // Region table dimensions
  localparam int PMA_NUM_REGIONS = 4;
  localparam int PMA_IDX_WIDTH = $clog2(PMA_NUM_REGIONS);

  // Event counter width
  localparam int STAT_WIDTH = 16;

  typedef struct packed {
    logic main;
    logic bufferable;
    logic cacheable;
  } pma_attr_t;

  // addr_low is inclusive, addr_high exclusive
  typedef struct packed {
    logic [31:0] addr_low;
    logic [31:0] addr_high;
    pma_attr_t   attr;
  } pma_region_t;

  // Region 2 overlaps the upper half of region 1
  localparam pma_region_t PMA_REGIONS [PMA_NUM_REGIONS] = '{
    '{addr_low: 32'h0000_0000, addr_high: 32'h0001_0000,
      attr: '{main: 1'b1, bufferable: 1'b0, cacheable: 1'b1}},
    '{addr_low: 32'h1000_0000, addr_high: 32'h1001_0000,
      attr: '{main: 1'b1, bufferable: 1'b1, cacheable: 1'b1}},
    '{addr_low: 32'h1000_8000, addr_high: 32'h1001_8000,
      attr: '{main: 1'b0, bufferable: 1'b0, cacheable: 1'b0}},
    '{addr_low: 32'h2000_0000, addr_high: 32'h2000_1000,
      attr: '{main: 1'b0, bufferable: 1'b1, cacheable: 1'b0}}
  };

  // Debug module range, reachable only in debug mode
  localparam logic [31:0] DM_ADDR_LOW  = 32'h1A11_0000;
  localparam logic [31:0] DM_ADDR_HIGH = 32'h1A11_1000;

  typedef enum logic [1:0] {ACC_LOAD, ACC_STORE, ACC_EXEC} pma_access_e;

  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] wdata;
    logic [3:0]  sel;
    pma_access_e kind;
    logic        dbg;
  } pma_core_req_t;

  // attr is forwarded as bus tags
  typedef struct packed {
    logic [31:0] adr;
    logic [31:0] wdata;
    logic [3:0]  sel;
    logic        we;
    pma_attr_t   attr;
  } pma_bus_req_t;

  typedef struct packed {
    logic [PMA_NUM_REGIONS-1:0] match_list;
    logic                       have_match;
    logic [PMA_IDX_WIDTH-1:0]   match_idx;
    logic                       override_dm;
    logic                       multi_match;
    pma_attr_t                  attr;
  } pma_status_t;

  typedef struct packed {
    logic valid;
    logic allowed;
    logic multi;
  } pma_event_t;

  typedef enum logic [1:0] {ST_IDLE, ST_LOOKUP, ST_BUS, ST_RESP} pma_state_e;

endpackage

/* logic/pma_region_match.sv */
`timescale 1ns/10ps

module pma_region_match (
  input  logic [31:0]          addr_i,
  input  logic                 dbg_i,
  output pma_pkg::pma_status_t status_o
);

  logic [pma_pkg::PMA_NUM_REGIONS-1:0] hit;
  logic                                in_dm_range;
  logic [pma_pkg::PMA_IDX_WIDTH-1:0]   sel_idx;
  pma_pkg::pma_attr_t                  sel_attr;

  // Per-region range compare
  always_comb begin
    for (int i = 0; i < pma_pkg::PMA_NUM_REGIONS; i++) begin
      hit[i] = (addr_i >= pma_pkg::PMA_REGIONS[i].addr_low) &&
               (addr_i < pma_pkg::PMA_REGIONS[i].addr_high);
    end
  end

  // Priority pick
  // Walk downwards so the lowest matching index is left standing
  always_comb begin
    sel_idx  = '0;
    sel_attr = '0;
    for (int i = pma_pkg::PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel_idx  = i[pma_pkg::PMA_IDX_WIDTH-1:0];
        sel_attr = pma_pkg::PMA_REGIONS[i].attr;
      end
    end
  end

  assign in_dm_range = (addr_i >= pma_pkg::DM_ADDR_LOW) &&
                       (addr_i < pma_pkg::DM_ADDR_HIGH);

  always_comb begin
    status_o             = '0;
    status_o.match_list  = hit;
    status_o.have_match  = |hit;
    status_o.multi_match = ($countones(hit) > 1);
    status_o.match_idx   = sel_idx;
    status_o.attr        = sel_attr;

    // Debug mode accesses to the DM range are treated as main memory
    if (dbg_i && in_dm_range) begin
      status_o.override_dm     = 1'b1;
      status_o.attr.main       = 1'b1;
      status_o.attr.bufferable = 1'b0;
      status_o.attr.cacheable  = 1'b0;
    end
  end

endmodule

/* logic/pma_mpu.sv */
`timescale 1ns/10ps

module pma_mpu (
  input  logic                    clk_ungated,
  input  logic                    rst_n,

  // Core side, Wishbone slave
  input  logic                    core_cyc_i,
  input  logic                    core_stb_i,
  input  pma_pkg::pma_core_req_t  core_req_i,
  output logic                    core_ack_o,
  output logic                    core_err_o,
  output logic [31:0]             core_rdata_o,

  // System side, Wishbone master
  output logic                    bus_cyc_o,
  output logic                    bus_stb_o,
  output pma_pkg::pma_bus_req_t   bus_req_o,
  input  logic                    bus_ack_i,
  input  logic                    bus_err_i,
  input  logic [31:0]             bus_rdata_i,

  // Region lookup
  output logic [31:0]             lookup_addr_o,
  output logic                    lookup_dbg_o,
  input  pma_pkg::pma_status_t    status_i,

  // Event counters
  output pma_pkg::pma_event_t     event_o
);

  pma_pkg::pma_state_e    state_q;
  pma_pkg::pma_state_e    state_d;
  pma_pkg::pma_core_req_t req_q;
  logic                   resp_err_q;
  logic                   resp_err_d;
  logic [31:0]            rdata_q;
  logic                   req_start;
  logic                   exec_io;
  logic                   allowed;

  assign req_start = core_cyc_i && core_stb_i;

  // Instruction fetch from I/O space is refused
  assign exec_io = (req_q.kind == pma_pkg::ACC_EXEC) && !status_i.attr.main;
  assign allowed = (status_i.have_match || status_i.override_dm) && !exec_io;

  always_comb begin
    state_d    = state_q;
    resp_err_d = resp_err_q;
    case (state_q)
      pma_pkg::ST_IDLE: begin
        if (req_start) begin
          state_d = pma_pkg::ST_LOOKUP;
        end
      end
      pma_pkg::ST_LOOKUP: begin
        resp_err_d = !allowed;
        state_d    = allowed ? pma_pkg::ST_BUS : pma_pkg::ST_RESP;
      end
      pma_pkg::ST_BUS: begin
        // Wait states from the slave keep us here
        if (bus_ack_i || bus_err_i) begin
          resp_err_d = bus_err_i;
          state_d    = pma_pkg::ST_RESP;
        end
      end
      pma_pkg::ST_RESP: begin
        state_d = pma_pkg::ST_IDLE;
      end
      default: begin
        state_d = pma_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= pma_pkg::ST_IDLE;
      resp_err_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      resp_err_q <= resp_err_d;
    end
  end

  // Request and read data capture
  always_ff @(posedge clk_ungated) begin
    if (state_q == pma_pkg::ST_IDLE && req_start) begin
      req_q <= core_req_i;
    end
    if (state_q == pma_pkg::ST_BUS && bus_ack_i) begin
      rdata_q <= bus_rdata_i;
    end
  end

  assign lookup_addr_o = req_q.adr;
  assign lookup_dbg_o  = req_q.dbg;

  // One event per checked access, in the lookup cycle
  assign event_o.valid   = (state_q == pma_pkg::ST_LOOKUP);
  assign event_o.allowed = allowed;
  assign event_o.multi   = status_i.multi_match;

  assign bus_cyc_o = (state_q == pma_pkg::ST_BUS);
  assign bus_stb_o = (state_q == pma_pkg::ST_BUS);

  // Address is held in req_q, so the lookup result stays stable in ST_BUS
  always_comb begin
    bus_req_o.adr   = req_q.adr;
    bus_req_o.wdata = req_q.wdata;
    bus_req_o.sel   = req_q.sel;
    bus_req_o.we    = (req_q.kind == pma_pkg::ACC_STORE);
    bus_req_o.attr  = status_i.attr;
  end

  assign core_ack_o   = (state_q == pma_pkg::ST_RESP) && !resp_err_q;
  assign core_err_o   = (state_q == pma_pkg::ST_RESP) && resp_err_q;
  assign core_rdata_o = rdata_q;

endmodule

/* logic/pma_event_stats.sv */
`timescale 1ns/10ps

module pma_event_stats (
  input  logic                               clk_ungated,
  input  logic                               rst_n,
  input  pma_pkg::pma_event_t                event_i,
  output logic [pma_pkg::STAT_WIDTH-1:0]     allow_count_o,
  output logic [pma_pkg::STAT_WIDTH-1:0]     deny_count_o,
  output logic [pma_pkg::STAT_WIDTH-1:0]     multi_count_o
);

  // Counter slots: 0 allowed, 1 denied, 2 multi-match
  logic [2:0]                       inc;
  logic [pma_pkg::STAT_WIDTH-1:0]   cnt_q [3];

  assign inc[0] = event_i.valid && event_i.allowed;
  assign inc[1] = event_i.valid && !event_i.allowed;
  assign inc[2] = event_i.valid && event_i.multi;

  // Counters stick at all ones
  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 3; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (inc[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign allow_count_o = cnt_q[0];
  assign deny_count_o  = cnt_q[1];
  assign multi_count_o = cnt_q[2];

endmodule

/* logic/pma_subsystem.sv */
`timescale 1ns/10ps

module pma_subsystem (
  input  logic                           clk_ungated,
  input  logic                           rst_n,

  // Core side
  input  logic                           core_cyc_i,
  input  logic                           core_stb_i,
  input  pma_pkg::pma_core_req_t         core_req_i,
  output logic                           core_ack_o,
  output logic                           core_err_o,
  output logic [31:0]                    core_rdata_o,

  // System bus side
  output logic                           bus_cyc_o,
  output logic                           bus_stb_o,
  output pma_pkg::pma_bus_req_t          bus_req_o,
  input  logic                           bus_ack_i,
  input  logic                           bus_err_i,
  input  logic [31:0]                    bus_rdata_i,

  // Access statistics
  output logic [pma_pkg::STAT_WIDTH-1:0] allow_count_o,
  output logic [pma_pkg::STAT_WIDTH-1:0] deny_count_o,
  output logic [pma_pkg::STAT_WIDTH-1:0] multi_count_o
);

  logic [31:0]          lookup_addr;
  logic                 lookup_dbg;
  pma_pkg::pma_status_t lookup_status;
  pma_pkg::pma_event_t  mpu_event;

  pma_region_match i_pma_region_match (
    .addr_i   (lookup_addr),
    .dbg_i    (lookup_dbg),
    .status_o (lookup_status)
  );

  pma_mpu i_pma_mpu (
    .clk_ungated   (clk_ungated),
    .rst_n         (rst_n),
    .core_cyc_i    (core_cyc_i),
    .core_stb_i    (core_stb_i),
    .core_req_i    (core_req_i),
    .core_ack_o    (core_ack_o),
    .core_err_o    (core_err_o),
    .core_rdata_o  (core_rdata_o),
    .bus_cyc_o     (bus_cyc_o),
    .bus_stb_o     (bus_stb_o),
    .bus_req_o     (bus_req_o),
    .bus_ack_i     (bus_ack_i),
    .bus_err_i     (bus_err_i),
    .bus_rdata_i   (bus_rdata_i),
    .lookup_addr_o (lookup_addr),
    .lookup_dbg_o  (lookup_dbg),
    .status_i      (lookup_status),
    .event_o       (mpu_event)
  );

  pma_event_stats i_pma_event_stats (
    .clk_ungated   (clk_ungated),
    .rst_n         (rst_n),
    .event_i       (mpu_event),
    .allow_count_o (allow_count_o),
    .deny_count_o  (deny_count_o),
    .multi_count_o (multi_count_o)
  );

endmodule

/* tb/pma_subsystem_assertions.sv */
`timescale 1ns/10ps

module pma_subsystem_assertions (
  input logic                clk_ungated,
  input logic                rst_n,
  input logic                core_ack_i,
  input logic                core_err_i,
  input logic                bus_cyc_i,
  input logic                bus_stb_i,
  input logic                bus_ack_i,
  input logic                bus_err_i,
  input pma_pkg::pma_event_t event_i
);

  // Failure tally, read by the testbench at the end
  int failures = 0;

  no_ack_with_err: assert property (@(posedge clk_ungated) disable iff (!rst_n)
    !(core_ack_i && core_err_i))
    else begin
      failures++;
      $error("Core ack and err are high in the same cycle");
    end

  // Wishbone classic master holds stb until the slave answers
  stb_held: assert property (@(posedge clk_ungated) disable iff (!rst_n)
    bus_stb_i && !(bus_ack_i || bus_err_i) |=> bus_stb_i)
    else begin
      failures++;
      $error("Bus stb dropped before ack or err");
    end

  no_bus_after_deny: assert property (@(posedge clk_ungated) disable iff (!rst_n)
    event_i.valid && !event_i.allowed |=> !bus_cyc_i)
    else begin
      failures++;
      $error("Bus cycle started after a denied access");
    end

endmodule

bind pma_subsystem pma_subsystem_assertions i_pma_subsystem_assertions (
  .clk_ungated (clk_ungated),
  .rst_n       (rst_n),
  .core_ack_i  (core_ack_o),
  .core_err_i  (core_err_o),
  .bus_cyc_i   (bus_cyc_o),
  .bus_stb_i   (bus_stb_o),
  .bus_ack_i   (bus_ack_i),
  .bus_err_i   (bus_err_i),
  .event_i     (mpu_event)
);

/* tb/pma_subsystem_tb.sv */
`timescale 1ns/10ps

module pma_subsystem_tb;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 10;
  localparam int ACCESS_LIMIT  = 10;
  localparam int MAX_ACCESSES  = 40;
  // Three times the worst case of all accesses plus reset
  localparam int WATCHDOG_NS   = 3 * CLK_PERIOD_NS * (RESET_CYCLES + MAX_ACCESSES * ACCESS_LIMIT);

  // Bus tags as {main, bufferable, cacheable}
  localparam logic [2:0] TAGS_R0 = 3'b101;
  localparam logic [2:0] TAGS_R1 = 3'b111;
  localparam logic [2:0] TAGS_R3 = 3'b010;
  localparam logic [2:0] TAGS_DM = 3'b100;

  logic                           clk_ungated = 1'b0;
  logic                           rst_n;
  logic                           core_cyc;
  logic                           core_stb;
  pma_pkg::pma_core_req_t         core_req;
  logic                           core_ack;
  logic                           core_err;
  logic [31:0]                    core_rdata;
  logic                           bus_cyc;
  logic                           bus_stb;
  pma_pkg::pma_bus_req_t          bus_req;
  logic                           bus_ack;
  logic                           bus_err;
  logic [31:0]                    bus_rdata;
  logic [pma_pkg::STAT_WIDTH-1:0] allow_count;
  logic [pma_pkg::STAT_WIDTH-1:0] deny_count;
  logic [pma_pkg::STAT_WIDTH-1:0] multi_count;

  // Slave memory and what the slave saw last
  logic [31:0] mem [256];
  int          bus_starts = 0;
  logic [2:0]  seen_attr;
  logic        seen_we;
  logic [31:0] seen_adr;
  logic [3:0]  seen_sel;

  // Result of the last access and running tallies
  logic        got_err;
  logic [31:0] got_rdata;
  int          got_cycles;
  int          got_bus;
  int          exp_allow = 0;
  int          exp_deny = 0;
  int          exp_multi = 0;

  always #(CLK_PERIOD_NS / 2) clk_ungated = ~clk_ungated;

  pma_subsystem i_pma_subsystem (
    .clk_ungated   (clk_ungated),
    .rst_n         (rst_n),
    .core_cyc_i    (core_cyc),
    .core_stb_i    (core_stb),
    .core_req_i    (core_req),
    .core_ack_o    (core_ack),
    .core_err_o    (core_err),
    .core_rdata_o  (core_rdata),
    .bus_cyc_o     (bus_cyc),
    .bus_stb_o     (bus_stb),
    .bus_req_o     (bus_req),
    .bus_ack_i     (bus_ack),
    .bus_err_i     (bus_err),
    .bus_rdata_i   (bus_rdata),
    .allow_count_o (allow_count),
    .deny_count_o  (deny_count),
    .multi_count_o (multi_count)
  );

  // Wishbone slave with 0 to 3 wait states, error at the last word of region 3
  initial begin : bus_slave
    logic [7:0] idx;
    int         waits;
    bus_ack   = 1'b0;
    bus_err   = 1'b0;
    bus_rdata = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hC0DE_0000 + 32'(i);
    end
    forever begin
      @(posedge clk_ungated);
      #1;
      if (bus_cyc && bus_stb) begin
        bus_starts++;
        idx       = bus_req.adr[9:2];
        seen_attr = bus_req.attr;
        seen_we   = bus_req.we;
        seen_adr  = bus_req.adr;
        seen_sel  = bus_req.sel;
        waits     = int'($urandom % 4);
        repeat (waits) @(posedge clk_ungated);
        if (waits > 0) begin
          #1;
        end
        if (bus_req.adr == 32'h2000_0FFC) begin
          bus_err = 1'b1;
        end else if (bus_req.we) begin
          mem[idx] = bus_req.wdata;
          bus_ack  = 1'b1;
        end else begin
          bus_rdata = mem[idx];
          bus_ack   = 1'b1;
        end
        @(posedge clk_ungated);
        #1;
        bus_ack = 1'b0;
        bus_err = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("TESTS FAILED");
    $fatal(1, "Watchdog timeout");
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "Stopping at first error");
    end
  endtask

  // Starts at 1 ns after an edge and returns there, with cyc and stb low
  task automatic run_access(input logic [31:0] adr, input logic [31:0] wdata,
                            input pma_pkg::pma_access_e kind, input logic dbg);
    int starts_before;
    starts_before  = bus_starts;
    core_req.adr   = adr;
    core_req.wdata = wdata;
    // Loads and fetches use a random nonzero byte enable
    core_req.sel   = (kind == pma_pkg::ACC_STORE) ? 4'hF : 4'($urandom_range(15, 1));
    core_req.kind  = kind;
    core_req.dbg   = dbg;
    core_cyc       = 1'b1;
    core_stb       = 1'b1;
    got_cycles     = 0;
    do begin
      @(posedge clk_ungated);
      #1;
      got_cycles++;
    end while (!(core_ack || core_err) && got_cycles < ACCESS_LIMIT);
    if (!(core_ack || core_err)) begin
      $display("No response from the DUT for the access to 0x%08h", adr);
      $display("TESTS FAILED");
      $fatal(1, "Access timeout");
    end
    got_err   = core_err;
    got_rdata = core_rdata;
    got_bus   = bus_starts - starts_before;
    @(posedge clk_ungated);
    #1;
    core_cyc = 1'b0;
    core_stb = 1'b0;
    // ack and err are single cycle pulses
    check_value("run_access response pulse", 0, 32'({core_ack, core_err}));
    @(posedge clk_ungated);
    #1;
  endtask

  task automatic expect_allowed(input string name, input logic [2:0] tags, input logic err);
    check_value({name, " err"}, 32'(err), 32'(got_err));
    check_value({name, " bus cycles"}, 1, 32'(got_bus));
    check_value({name, " tags"}, 32'(tags), 32'(seen_attr));
    check_value({name, " bus adr"}, core_req.adr, seen_adr);
    check_value({name, " bus sel"}, 32'(core_req.sel), 32'(seen_sel));
    exp_allow++;
  endtask

  task automatic expect_denied(input string name);
    check_value({name, " err"}, 1, 32'(got_err));
    check_value({name, " latency"}, 2, 32'(got_cycles));
    check_value({name, " bus cycles"}, 0, 32'(got_bus));
    exp_deny++;
  endtask

  task automatic test_main_access();
    run_access(32'h0000_0020, 32'hA5A5_0001, pma_pkg::ACC_STORE, 1'b0);
    expect_allowed("test_main_access store r0", TAGS_R0, 1'b0);
    check_value("test_main_access store r0 we", 1, 32'(seen_we));
    run_access(32'h1000_0010, 32'h5A5A_0002, pma_pkg::ACC_STORE, 1'b0);
    expect_allowed("test_main_access store r1", TAGS_R1, 1'b0);
    run_access(32'h0000_0020, '0, pma_pkg::ACC_LOAD, 1'b0);
    expect_allowed("test_main_access load r0", TAGS_R0, 1'b0);
    check_value("test_main_access load r0 we", 0, 32'(seen_we));
    check_value("test_main_access load r0 data", 32'hA5A5_0001, got_rdata);
    run_access(32'h1000_0010, '0, pma_pkg::ACC_LOAD, 1'b0);
    expect_allowed("test_main_access load r1", TAGS_R1, 1'b0);
    check_value("test_main_access load r1 data", 32'h5A5A_0002, got_rdata);
    // Fetch from main memory is allowed
    run_access(32'h0000_0020, '0, pma_pkg::ACC_EXEC, 1'b0);
    expect_allowed("test_main_access exec r0", TAGS_R0, 1'b0);
    check_value("test_main_access exec r0 data", 32'hA5A5_0001, got_rdata);
  endtask

  task automatic test_denied();
    run_access(32'h3000_0000, '0, pma_pkg::ACC_LOAD, 1'b0);
    expect_denied("test_denied unmapped");
    // Region 3 is I/O space
    run_access(32'h2000_0100, '0, pma_pkg::ACC_EXEC, 1'b0);
    expect_denied("test_denied exec io");
  endtask

  task automatic test_overlap();
    int multi_before;
    multi_before = int'(multi_count);
    run_access(32'h1000_8000, '0, pma_pkg::ACC_LOAD, 1'b0);
    expect_allowed("test_overlap", TAGS_R1, 1'b0);
    check_value("test_overlap multi count", 32'(multi_before + 1), 32'(multi_count));
    exp_multi++;
  endtask

  task automatic test_debug_override();
    run_access(32'h1A11_0040, '0, pma_pkg::ACC_LOAD, 1'b1);
    expect_allowed("test_debug_override dbg", TAGS_DM, 1'b0);
    check_value("test_debug_override dbg data", 32'hC0DE_0010, got_rdata);
    run_access(32'h1A11_0040, '0, pma_pkg::ACC_LOAD, 1'b0);
    expect_denied("test_debug_override no dbg");
  endtask

  task automatic test_bus_error();
    int allow_before;
    int deny_before;
    allow_before = int'(allow_count);
    deny_before  = int'(deny_count);
    run_access(32'h2000_0FFC, '0, pma_pkg::ACC_LOAD, 1'b0);
    expect_allowed("test_bus_error", TAGS_R3, 1'b1);
    check_value("test_bus_error allow count", 32'(allow_before + 1), 32'(allow_count));
    check_value("test_bus_error deny count", 32'(deny_before), 32'(deny_count));
  endtask

  task automatic test_counters();
    check_value("test_counters allowed", 32'(exp_allow), 32'(allow_count));
    check_value("test_counters denied", 32'(exp_deny), 32'(deny_count));
    check_value("test_counters multi", 32'(exp_multi), 32'(multi_count));
  endtask

  initial begin : run_tests
    void'($urandom(91));
    rst_n    = 1'b0;
    core_cyc = 1'b0;
    core_stb = 1'b0;
    core_req = '0;
    repeat (RESET_CYCLES) @(posedge clk_ungated);
    #1;
    check_value("reset bus and core outputs", 0, 32'({core_ack, core_err, bus_cyc, bus_stb}));
    check_value("reset counters", 0, 32'({allow_count, deny_count}));
    check_value("reset multi counter", 0, 32'(multi_count));
    rst_n = 1'b1;
    @(posedge clk_ungated);
    #1;
    test_main_access();
    test_denied();
    test_overlap();
    test_debug_override();
    test_bus_error();
    test_counters();
    check_value("bound assertions", 0, 32'(i_pma_subsystem.i_pma_subsystem_assertions.failures));
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* pma_subsystem.f */
logic/pma_pkg.sv
logic/pma_region_match.sv
logic/pma_mpu.sv
logic/pma_event_stats.sv
logic/pma_subsystem.sv
tb/pma_subsystem_assertions.sv
tb/pma_subsystem_tb.sv

/* run_verilator.sh */
#!/bin/sh
# Build and run the PMA subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module pma_subsystem_tb \
  -Mdir obj_dir -o Vpma_subsystem_tb \
  -f pma_subsystem.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vpma_subsystem_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
